// ==== source/clint_params.svh ====
`ifndef CLINT_PARAMS_SVH
`define CLINT_PARAMS_SVH

// enabled rtc cycles per mtime increment
`define CLINT_RTC_PSC_DEFAULT 100

// register reset values
`define CLINT_MTIME_RST    64'h0000_0000_0000_0000
`define CLINT_MTIMECMP_RST 64'hffff_ffff_ffff_ffff // never fires after reset

// byte offsets in the clint window
`define CLINT_OFS_MSIP        (8'h00)
`define CLINT_OFS_MTIMECMP_LO (8'h10)
`define CLINT_OFS_MTIMECMP_HI (8'h14)
`define CLINT_OFS_MTIME_LO    (8'h18)
`define CLINT_OFS_MTIME_HI    (8'h1c)

`endif

// ==== source/icb_pkg.sv ====
package icb_pkg;

	localparam int ICB_ADDR_W = 32;
	localparam int ICB_DATA_W = 32;
	localparam int ICB_MASK_W = ICB_DATA_W / 8; // one bit per byte lane

	// command address
	typedef logic [ICB_ADDR_W-1:0] icb_addr_t;

	// write data on the command channel, read data on the response channel
	typedef logic [ICB_DATA_W-1:0] icb_data_t;

	// byte write mask
	typedef logic [ICB_MASK_W-1:0] icb_mask_t;

endpackage

// ==== source/clint_pkg.sv ====
`include "clint_params.svh"

package clint_pkg;

	// register index, taken from address bits 4:2
	typedef enum logic [2:0]
	{
		REG_MSIP    = 3'(`CLINT_OFS_MSIP >> 2),
		REG_NONE    = 3'd1, // 0x04..0x0c, read as zero
		REG_CMP_LO  = 3'(`CLINT_OFS_MTIMECMP_LO >> 2),
		REG_CMP_HI  = 3'(`CLINT_OFS_MTIMECMP_HI >> 2),
		REG_TIME_LO = 3'(`CLINT_OFS_MTIME_LO >> 2),
		REG_TIME_HI = 3'(`CLINT_OFS_MTIME_HI >> 2)
	} clint_reg_e;

	// mtime and mtimecmp
	typedef logic [63:0] clint_time_t;

	// unused word slots all fold onto REG_NONE
	function automatic clint_reg_e clint_decode(input logic [2:0] idx);
		case (idx)
			REG_MSIP, REG_CMP_LO, REG_CMP_HI, REG_TIME_LO, REG_TIME_HI:
				clint_decode = clint_reg_e'(idx);
			default:
				clint_decode = REG_NONE;
		endcase
	endfunction

endpackage

// ==== source/clint_mtime.sv ====
`include "clint_params.svh"

module clint_mtime
	import icb_pkg::*, clint_pkg::*;
#(
	parameter int RTC_PSC = `CLINT_RTC_PSC_DEFAULT
)(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        rtc_en,
	input  clint_reg_e  wr_sel,
	input  icb_data_t   wr_data,
	input  icb_mask_t   wr_be,
	input  clint_reg_e  rd_sel,
	output clint_time_t mtime,
	output icb_data_t   mtime_rdata
);

	localparam int PSC_W = $clog2(RTC_PSC);

	logic [PSC_W-1:0] psc_cnt;
	logic             psc_wrap;
	logic             rtc_tick;
	logic [7:0]       byte_we;  // one enable per byte of mtime
	clint_time_t      wr_word;
	clint_time_t      mtime_inc;

	assign psc_wrap = (psc_cnt == PSC_W'(RTC_PSC - 1));

	// prescaler only moves while the rtc is enabled
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			psc_cnt <= '0;
		else if (rtc_en)
			psc_cnt <= psc_wrap ? '0 : psc_cnt + 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rtc_tick <= 1'b0;
		else
			rtc_tick <= rtc_en & psc_wrap;
	end

	assign byte_we   = {wr_be & {4{wr_sel == REG_TIME_HI}}, wr_be & {4{wr_sel == REG_TIME_LO}}};
	assign wr_word   = {wr_data, wr_data}; // same lanes for lo and hi word
	assign mtime_inc = mtime + 64'd1;

	// bus write wins over the tick, byte by byte
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mtime <= `CLINT_MTIME_RST;
		else
		begin
			for (int i = 0; i < 8; i++)
			begin
				if (byte_we[i])
					mtime[8*i +: 8] <= wr_word[8*i +: 8];
				else if (rtc_tick)
					mtime[8*i +: 8] <= mtime_inc[8*i +: 8];
			end
		end
	end

	always_comb
	begin
		case (rd_sel)
			REG_TIME_LO: mtime_rdata = mtime[31:0];
			REG_TIME_HI: mtime_rdata = mtime[63:32];
			default:     mtime_rdata = '0; // not ours
		endcase
	end

endmodule

// ==== source/clint_irq_ctrl.sv ====
`include "clint_params.svh"

module clint_irq_ctrl
	import icb_pkg::*, clint_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  clint_reg_e  wr_sel,
	input  icb_data_t   wr_data,
	input  icb_mask_t   wr_be,
	input  clint_reg_e  rd_sel,
	input  clint_time_t mtime,
	output icb_data_t   irq_rdata,
	output logic        sw_irq,
	output logic        tmr_irq
);

	logic        msip;
	clint_time_t mtimecmp;
	logic [7:0]  cmp_we;
	clint_time_t wr_word;
	logic        tmr_hit;

	// only bit 0 of byte 0 is implemented
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			msip <= 1'b0;
		else if (wr_be[0] && wr_sel == REG_MSIP)
			msip <= wr_data[0];
	end

	assign sw_irq = msip;

	assign cmp_we  = {wr_be & {4{wr_sel == REG_CMP_HI}}, wr_be & {4{wr_sel == REG_CMP_LO}}};
	assign wr_word = {wr_data, wr_data};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mtimecmp <= `CLINT_MTIMECMP_RST;
		else
		begin
			for (int i = 0; i < 8; i++)
			begin
				if (cmp_we[i])
					mtimecmp[8*i +: 8] <= wr_word[8*i +: 8];
			end
		end
	end

	assign tmr_hit = (mtime >= mtimecmp); // unsigned 64-bit compare

	// one cycle behind the compare
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tmr_irq <= 1'b0;
		else
			tmr_irq <= tmr_hit;
	end

	always_comb
	begin
		case (rd_sel)
			REG_MSIP:   irq_rdata = {31'd0, msip};
			REG_CMP_LO: irq_rdata = mtimecmp[31:0];
			REG_CMP_HI: irq_rdata = mtimecmp[63:32];
			default:    irq_rdata = '0;
		endcase
	end

endmodule

// ==== source/icb_clint_port.sv ====
module icb_clint_port
	import icb_pkg::*, clint_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	// command channel
	input  icb_addr_t  cmd_addr,
	input  logic       cmd_read,
	input  icb_data_t  cmd_wdata,
	input  icb_mask_t  cmd_wmask,
	input  logic       cmd_valid,
	output logic       cmd_ready,

	// response channel
	output icb_data_t  rsp_rdata,
	output logic       rsp_valid,
	input  logic       rsp_ready,

	// register side
	output clint_reg_e wr_sel,
	output icb_data_t  wr_data,
	output icb_mask_t  wr_be,
	output clint_reg_e rd_sel,
	input  icb_data_t  mtime_rdata,
	input  icb_data_t  irq_rdata
);

	logic       cmd_fire;
	clint_reg_e reg_idx;

	// one transaction in flight at most
	assign cmd_ready = ~rsp_valid;
	assign cmd_fire  = cmd_valid & cmd_ready;

	assign reg_idx = clint_decode(cmd_addr[4:2]);

	assign wr_sel  = reg_idx;
	assign rd_sel  = reg_idx;
	assign wr_data = cmd_wdata;
	assign wr_be   = (cmd_fire && !cmd_read) ? cmd_wmask : '0;

	// blocks return zero outside their own indices, so OR is enough
	always_ff @(posedge clk)
	begin
		if (cmd_fire && cmd_read)
			rsp_rdata <= mtime_rdata | irq_rdata;
	end

	// set on accept, clear when the master takes the response
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rsp_valid <= 1'b0;
		else if (rsp_valid ? rsp_ready : cmd_valid)
			rsp_valid <= ~rsp_valid;
	end

endmodule

// ==== source/icb_clint_top.sv ====
`include "clint_params.svh"

module icb_clint_top
	import icb_pkg::*, clint_pkg::*;
#(
	parameter int RTC_PSC = `CLINT_RTC_PSC_DEFAULT
)(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      rtc_en,

	// icb slave
	input  icb_addr_t cmd_addr,
	input  logic      cmd_read,
	input  icb_data_t cmd_wdata,
	input  icb_mask_t cmd_wmask,
	input  logic      cmd_valid,
	output logic      cmd_ready,
	output icb_data_t rsp_rdata,
	output logic      rsp_valid,
	input  logic      rsp_ready,

	// interrupt requests
	output logic      sw_irq,
	output logic      tmr_irq
);

	clint_reg_e  wr_sel;
	icb_data_t   wr_data;
	icb_mask_t   wr_be;
	clint_reg_e  rd_sel;
	icb_data_t   mtime_rdata;
	icb_data_t   irq_rdata;
	clint_time_t mtime;

	icb_clint_port u_port (
		.clk         (clk),
		.rst_n       (rst_n),
		.cmd_addr    (cmd_addr),
		.cmd_read    (cmd_read),
		.cmd_wdata   (cmd_wdata),
		.cmd_wmask   (cmd_wmask),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.rsp_rdata   (rsp_rdata),
		.rsp_valid   (rsp_valid),
		.rsp_ready   (rsp_ready),
		.wr_sel      (wr_sel),
		.wr_data     (wr_data),
		.wr_be       (wr_be),
		.rd_sel      (rd_sel),
		.mtime_rdata (mtime_rdata),
		.irq_rdata   (irq_rdata)
	);

	// time base
	clint_mtime #(
		.RTC_PSC (RTC_PSC)
	) u_mtime (
		.clk         (clk),
		.rst_n       (rst_n),
		.rtc_en      (rtc_en),
		.wr_sel      (wr_sel),
		.wr_data     (wr_data),
		.wr_be       (wr_be),
		.rd_sel      (rd_sel),
		.mtime       (mtime),
		.mtime_rdata (mtime_rdata)
	);

	// msip, mtimecmp and the timer compare
	clint_irq_ctrl u_irq (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_sel    (wr_sel),
		.wr_data   (wr_data),
		.wr_be     (wr_be),
		.rd_sel    (rd_sel),
		.mtime     (mtime),
		.irq_rdata (irq_rdata),
		.sw_irq    (sw_irq),
		.tmr_irq   (tmr_irq)
	);

endmodule

// ==== verif/icb_clint_assertions.sv ====
module icb_clint_assertions
	import icb_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input logic      cmd_ready,
	input logic      rsp_valid,
	input logic      rsp_ready,
	input icb_data_t rsp_rdata,
	input logic      sw_irq,
	input logic      tmr_irq
);

	timeunit 1ns;
	timeprecision 100ps;

	int assert_errs = 0; // read by the testbench at the end of the run

	// at most one transaction in flight
	a_ready_inv: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_ready == !rsp_valid)
	else
	begin
		$error("cmd_ready is not the inverse of rsp_valid");
		assert_errs++;
	end

	a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
	else
	begin
		$error("response dropped or changed while rsp_ready was low");
		assert_errs++;
	end

	// both requests quiet right after reset
	a_irq_reset: assert property (@(posedge clk) $rose(rst_n) |-> !sw_irq && !tmr_irq)
	else
	begin
		$error("interrupt request high in the first cycle after reset");
		assert_errs++;
	end

endmodule

bind icb_clint_top icb_clint_assertions u_assertions (.*);

// ==== verif/icb_clint_tb.sv ====
`include "clint_params.svh"

module icb_clint_tb
	import icb_pkg::*, clint_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int        PSC        = 4;
	localparam int        MAX_CYCLES = 4000; // about twice the summed test lengths
	localparam icb_addr_t CLINT_BASE = 32'h0200_0000;

	logic        clk       = 1'b0;
	logic        rst_n     = 1'b0;
	logic        rtc_en    = 1'b0;
	icb_addr_t   cmd_addr  = '0;
	logic        cmd_read  = 1'b0;
	icb_data_t   cmd_wdata = '0;
	icb_mask_t   cmd_wmask = '0;
	logic        cmd_valid = 1'b0;
	logic        rsp_ready = 1'b1;
	logic        cmd_ready;
	icb_data_t   rsp_rdata;
	logic        rsp_valid;
	logic        sw_irq;
	logic        tmr_irq;

	logic [31:0] rng_state = 32'h7fbe_9dff;
	int          err_cnt   = 0;
	int          test_cnt  = 0;
	int          fail_cnt  = 0;
	int          cycle_cnt = 0;
	clint_time_t exp_cmp;  // model of mtimecmp
	clint_time_t exp_time; // model of mtime, valid while rtc_en is low

	icb_clint_top #(.RTC_PSC(PSC)) UUT (.*);

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == MAX_CYCLES)
		begin
			$display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// only the enabled byte lanes take the new data
	function automatic icb_data_t merge_bytes(input icb_data_t old_word, input icb_data_t new_word,
		input icb_mask_t mask);
		icb_data_t res;
		res = old_word;
		for (int i = 0; i < 4; i++)
			if (mask[i])
				res[8*i +: 8] = new_word[8*i +: 8];
		return res;
	endfunction

	function automatic icb_addr_t addr_of(input logic [7:0] ofs);
		return CLINT_BASE | icb_addr_t'(ofs);
	endfunction

	function automatic icb_addr_t reg_addr(input clint_reg_e r);
		case (r)
			REG_CMP_LO:  return addr_of(`CLINT_OFS_MTIMECMP_LO);
			REG_CMP_HI:  return addr_of(`CLINT_OFS_MTIMECMP_HI);
			REG_TIME_LO: return addr_of(`CLINT_OFS_MTIME_LO);
			REG_TIME_HI: return addr_of(`CLINT_OFS_MTIME_HI);
			default:     return addr_of(`CLINT_OFS_MSIP);
		endcase
	endfunction

	task automatic check_word(input string name, input icb_data_t exp, input icb_data_t act);
		if (act !== exp)
		begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_time(input string name, input clint_time_t exp, input clint_time_t act);
		if (act !== exp)
		begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
			err_cnt++;
		end
	endtask

	// returns on the accepting edge
	task automatic icb_issue(input icb_addr_t addr, input logic rd, input icb_data_t wdata,
		input icb_mask_t mask);
		@(posedge clk);
		cmd_addr  <= addr;
		cmd_read  <= rd;
		cmd_wdata <= wdata;
		cmd_wmask <= mask;
		cmd_valid <= 1'b1;
		do
			@(negedge clk);
		while (!cmd_ready);
		@(posedge clk);
		cmd_valid <= 1'b0;
	endtask

	task automatic icb_take(output icb_data_t data);
		do
			@(negedge clk);
		while (!(rsp_valid && rsp_ready));
		data = rsp_rdata;
		@(posedge clk); // response handshake
	endtask

	task automatic icb_write(input icb_addr_t addr, input icb_data_t data, input icb_mask_t mask);
		icb_data_t unused;
		icb_issue(addr, 1'b0, data, mask);
		icb_take(unused);
	endtask

	task automatic icb_read(input icb_addr_t addr, output icb_data_t data);
		icb_issue(addr, 1'b1, '0, '0);
		icb_take(data);
	endtask

	task automatic write64(input logic [7:0] lo_ofs, input clint_time_t value);
		icb_write(addr_of(lo_ofs), value[31:0], 4'hf);
		icb_write(addr_of(lo_ofs + 8'd4), value[63:32], 4'hf);
	endtask

	task automatic read64(input logic [7:0] lo_ofs, output clint_time_t value);
		icb_data_t lo;
		icb_data_t hi;
		icb_read(addr_of(lo_ofs), lo);
		icb_read(addr_of(lo_ofs + 8'd4), hi);
		value = {hi, lo};
	endtask

	task automatic end_test(input string name, input int err_before);
		test_cnt++;
		if (err_cnt == err_before)
			$display("test %s: ok", name);
		else
		begin
			fail_cnt++;
			$display("test %s: %0d errors", name, err_cnt - err_before);
		end
	endtask

	task automatic reset_values_test();
		int          err0;
		icb_data_t   word;
		clint_time_t t;
		err0 = err_cnt;
		@(negedge clk);
		check_bit("reset sw_irq", 1'b0, sw_irq);
		check_bit("reset tmr_irq", 1'b0, tmr_irq);
		icb_read(addr_of(`CLINT_OFS_MSIP), word);
		check_word("reset msip", 32'd0, word);
		exp_cmp  = `CLINT_MTIMECMP_RST;
		exp_time = 64'd0;
		read64(`CLINT_OFS_MTIMECMP_LO, t);
		check_time("reset mtimecmp", exp_cmp, t);
		read64(`CLINT_OFS_MTIME_LO, t);
		check_time("reset mtime", exp_time, t);
		end_test("reset_values", err0);
	endtask

	task automatic soft_irq_test();
		int        err0;
		icb_data_t word;
		err0 = err_cnt;
		icb_write(addr_of(`CLINT_OFS_MSIP), 32'h1, 4'h1);
		@(negedge clk);
		check_bit("msip set sw_irq", 1'b1, sw_irq);
		icb_read(addr_of(`CLINT_OFS_MSIP), word);
		check_word("msip set readback", 32'd1, word);
		icb_write(addr_of(`CLINT_OFS_MSIP), 32'h0, 4'he); // lane 0 masked off
		icb_read(addr_of(`CLINT_OFS_MSIP), word);
		check_word("msip masked readback", 32'd1, word);
		icb_write(addr_of(`CLINT_OFS_MSIP), 32'h0, 4'hf);
		@(negedge clk);
		check_bit("msip clear sw_irq", 1'b0, sw_irq);
		icb_read(addr_of(`CLINT_OFS_MSIP), word);
		check_word("msip clear readback", 32'd0, word);
		for (int i = 1; i < 4; i++)
		begin
			icb_write(addr_of(8'(4 * i)), next_rand(), 4'hf);
			icb_read(addr_of(8'(4 * i)), word);
			check_word($sformatf("empty slot 0x%02h", 4 * i), 32'd0, word);
		end
		end_test("soft_irq", err0);
	endtask

	task automatic masked_writes_test();
		clint_reg_e  regs[4];
		int          err0;
		clint_reg_e  r;
		icb_data_t   data;
		icb_mask_t   mask;
		icb_data_t   word;
		clint_time_t t;
		err0 = err_cnt;
		regs = '{REG_CMP_LO, REG_CMP_HI, REG_TIME_LO, REG_TIME_HI};
		for (int n = 0; n < 16; n++)
		begin
			r    = regs[n % 4];
			data = next_rand();
			mask = icb_mask_t'(next_rand());
			icb_write(reg_addr(r), data, mask);
			icb_read(reg_addr(r), word);
			case (r)
				REG_CMP_LO:  exp_cmp[31:0]   = merge_bytes(exp_cmp[31:0], data, mask);
				REG_CMP_HI:  exp_cmp[63:32]  = merge_bytes(exp_cmp[63:32], data, mask);
				REG_TIME_LO: exp_time[31:0]  = merge_bytes(exp_time[31:0], data, mask);
				default:     exp_time[63:32] = merge_bytes(exp_time[63:32], data, mask);
			endcase
			check_word($sformatf("masked %s", r.name()),
				(n % 4 < 2) ? exp_cmp[32*(n%2) +: 32] : exp_time[32*(n%2) +: 32], word);
		end
		read64(`CLINT_OFS_MTIMECMP_LO, t);
		check_time("masked mtimecmp", exp_cmp, t);
		read64(`CLINT_OFS_MTIME_LO, t);
		check_time("masked mtime", exp_time, t);
		end_test("masked_writes", err0);
	endtask

	task automatic counting_test();
		int          err0;
		clint_time_t start;
		clint_time_t t;
		clint_time_t delta;
		err0 = err_cnt;
		start[63:32] = next_rand() & 32'h7fff_ffff;
		start[31:0]  = 32'hffff_fff8 | (next_rand() & 32'h3); // carry within 8 ticks
		write64(`CLINT_OFS_MTIME_LO, start);
		@(posedge clk);
		rtc_en <= 1'b1;
		repeat (40) @(posedge clk);
		rtc_en <= 1'b0;
		repeat (2) @(posedge clk); // last tick lands one edge late
		read64(`CLINT_OFS_MTIME_LO, t);
		delta = t - start;
		if (delta < 64'd9 || delta > 64'd10)
		begin
			$display("[ERROR] counting increase: expected 9 to 10, actual %0d", delta);
			err_cnt++;
		end
		check_word("counting carry", start[63:32] + 32'd1, t[63:32]);
		end_test("counting", err0);
	endtask

	task automatic timer_irq_test();
		int err0;
		err0 = err_cnt;
		exp_time[63:32] = next_rand() & 32'h7fff_ffff;
		exp_time[31:0]  = next_rand();
		write64(`CLINT_OFS_MTIME_LO, exp_time);
		exp_cmp = exp_time + 64'd100;
		write64(`CLINT_OFS_MTIMECMP_LO, exp_cmp);
		repeat (2) @(negedge clk);
		check_bit("timer below compare", 1'b0, tmr_irq);
		exp_time = exp_cmp;
		write64(`CLINT_OFS_MTIME_LO, exp_time);
		repeat (2) @(negedge clk);
		check_bit("timer at compare", 1'b1, tmr_irq);
		exp_cmp[63:32] = exp_cmp[63:32] + 32'd1;
		icb_write(addr_of(`CLINT_OFS_MTIMECMP_HI), exp_cmp[63:32], 4'hf);
		repeat (2) @(negedge clk);
		check_bit("timer compare raised", 1'b0, tmr_irq);
		end_test("timer_irq", err0);
	endtask

	task automatic back_pressure_test();
		int        err0;
		icb_data_t held;
		icb_data_t word;
		err0 = err_cnt;
		@(posedge clk);
		rsp_ready <= 1'b0;
		icb_issue(addr_of(`CLINT_OFS_MTIMECMP_HI), 1'b1, '0, '0);
		// a second read of msip waits behind the stalled response
		cmd_addr  <= addr_of(`CLINT_OFS_MSIP);
		cmd_valid <= 1'b1;
		@(negedge clk);
		held = rsp_rdata;
		repeat (5)
		begin
			@(negedge clk);
			check_bit("stalled rsp_valid", 1'b1, rsp_valid);
			check_bit("stalled cmd_ready", 1'b0, cmd_ready);
			check_word("stalled rsp_rdata", held, rsp_rdata);
		end
		@(posedge clk);
		rsp_ready <= 1'b1;
		cmd_valid <= 1'b0;
		icb_take(word);
		check_word("released readback", exp_cmp[63:32], word);
		end_test("back_pressure", err0);
	endtask

	initial
	begin
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		reset_values_test();
		soft_irq_test();
		masked_writes_test();
		counting_test();
		timer_irq_test();
		back_pressure_test();
		$display("tests run %0d, tests failed %0d, check errors %0d, assertion errors %0d",
			test_cnt, fail_cnt, err_cnt, UUT.u_assertions.assert_errs);
		if (err_cnt == 0 && UUT.u_assertions.assert_errs == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+source
source/icb_pkg.sv
source/clint_pkg.sv
source/clint_mtime.sv
source/clint_irq_ctrl.sv
source/icb_clint_port.sv
source/icb_clint_top.sv
verif/icb_clint_assertions.sv
verif/icb_clint_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := icb_clint_tb
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
RUN_FLAGS  := +verilator+error+limit+100
PASS_MSG   := PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
